// ==== hdl/gpu_geom_pkg.sv ====
`default_nettype none

package gpu_geom_pkg;

  // Coordinate widths
  localparam int WIDTH_BITS = 10;
  localparam int HEIGHT_BITS = 9;

  // One colour channel
  localparam int CHANNEL_BITS = 8;

  localparam int OPCODE_BITS = 4;

  // Instruction opcodes
  localparam logic [OPCODE_BITS-1:0] OP_NOP = 4'd0;
  localparam logic [OPCODE_BITS-1:0] OP_FILL_RECT = 4'd1;
  localparam logic [OPCODE_BITS-1:0] OP_OUTLINE_RECT = 4'd2;

endpackage

`default_nettype wire

// ==== hdl/gpu_mem_pkg.sv ====
`default_nettype none

package gpu_mem_pkg;

  // Red in the top byte, then green, then blue
  localparam int PIXEL_BITS = 24;

  // Requester indices, lowest index wins the port
  localparam int REQ_FILL = 0;
  localparam int REQ_OUTLINE = 1;
  localparam int REQ_HOST = 2;
  localparam int NUM_REQ = 3;

endpackage

`default_nettype wire

// ==== hdl/gpu_instruction_fifo.sv ====
`default_nettype none

module gpu_instruction_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic clk,
  input  logic n_rst,
  input  logic push_i,
  input  logic pop_i,
  input  logic [gpu_geom_pkg::OPCODE_BITS-1:0] opcode_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x1_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y1_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x2_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y2_i,
  input  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] r_i,
  input  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] g_i,
  input  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] b_i,
  output logic [gpu_geom_pkg::OPCODE_BITS-1:0] opcode_o,
  output logic [gpu_geom_pkg::WIDTH_BITS-1:0] x1_o,
  output logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y1_o,
  output logic [gpu_geom_pkg::WIDTH_BITS-1:0] x2_o,
  output logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y2_o,
  output logic [gpu_geom_pkg::CHANNEL_BITS-1:0] r_o,
  output logic [gpu_geom_pkg::CHANNEL_BITS-1:0] g_o,
  output logic [gpu_geom_pkg::CHANNEL_BITS-1:0] b_o,
  output logic empty_o,
  output logic full_o
);

  localparam int PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int ENTRY_BITS = gpu_geom_pkg::OPCODE_BITS + 2 * gpu_geom_pkg::WIDTH_BITS
                            + 2 * gpu_geom_pkg::HEIGHT_BITS + 3 * gpu_geom_pkg::CHANNEL_BITS;

  logic [ENTRY_BITS-1:0] mem [FIFO_DEPTH];
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS:0] count;
  logic do_push;
  logic do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop = pop_i && !empty_o;
  assign empty_o = (count == '0);
  assign full_o = (count == FIFO_DEPTH[PTR_BITS:0]);

  // Head entry is visible without a pop
  assign {opcode_o, x1_o, y1_o, x2_o, y2_o, r_o, g_o, b_o} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= {opcode_i, x1_i, y1_i, x2_i, y2_i, r_i, g_i, b_i};
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!n_rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!n_rst) count <= FIFO_DEPTH);

endmodule

`default_nettype wire

// ==== hdl/gpu_command_dispatch.sv ====
`default_nettype none

module gpu_command_dispatch (
  input  logic clk,
  input  logic n_rst,
  input  logic empty_i,
  input  logic [gpu_geom_pkg::OPCODE_BITS-1:0] opcode_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x1_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y1_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x2_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y2_i,
  input  logic [gpu_mem_pkg::PIXEL_BITS-1:0] pixel_i,
  input  logic fill_busy_i,
  input  logic outline_busy_i,
  output logic pop_o,
  output logic fill_start_o,
  output logic outline_start_o,
  output logic [gpu_geom_pkg::WIDTH_BITS-1:0] x1_o,
  output logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y1_o,
  output logic [gpu_geom_pkg::WIDTH_BITS-1:0] x2_o,
  output logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y2_o,
  output logic [gpu_mem_pkg::PIXEL_BITS-1:0] pixel_o,
  output logic busy_o
);

  logic start_pending;
  logic engines_busy;

  assign start_pending = fill_start_o || outline_start_o;
  assign engines_busy = fill_busy_i || outline_busy_i;

  // Wait for the running engine and any start still in flight
  assign pop_o = !empty_i && !engines_busy && !start_pending;
  assign busy_o = !empty_i || engines_busy || start_pending;

  // Unknown opcodes and NOP pop without a start
  always_ff @(posedge clk) begin
    if (!n_rst) begin
      fill_start_o <= 1'b0;
      outline_start_o <= 1'b0;
    end else begin
      fill_start_o <= pop_o && (opcode_i == gpu_geom_pkg::OP_FILL_RECT);
      outline_start_o <= pop_o && (opcode_i == gpu_geom_pkg::OP_OUTLINE_RECT);
    end
  end

  // Shared by both engines
  always_ff @(posedge clk) begin
    if (pop_o) begin
      x1_o <= x1_i;
      y1_o <= y1_i;
      x2_o <= x2_i;
      y2_o <= y2_i;
      pixel_o <= pixel_i;
    end
  end

  a_one_start: assert property (@(posedge clk) disable iff (!n_rst)
    !(fill_start_o && outline_start_o));

endmodule

`default_nettype wire

// ==== hdl/gpu_rect_fill.sv ====
`default_nettype none

module gpu_rect_fill (
  input  logic clk,
  input  logic n_rst,
  input  logic start_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x1_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y1_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x2_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y2_i,
  input  logic [gpu_mem_pkg::PIXEL_BITS-1:0] pixel_i,
  input  logic gnt_i,
  output logic req_o,
  output logic [gpu_geom_pkg::WIDTH_BITS-1:0] addr_x_o,
  output logic [gpu_geom_pkg::HEIGHT_BITS-1:0] addr_y_o,
  output logic [gpu_mem_pkg::PIXEL_BITS-1:0] pixel_o,
  output logic busy_o,
  output logic done_o
);

  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x_min;
  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x_max;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y_max;
  logic last_x;
  logic last_pixel;

  assign last_x = (addr_x_o == x_max);
  assign last_pixel = last_x && (addr_y_o == y_max);
  assign req_o = busy_o;
  assign done_o = busy_o && gnt_i && last_pixel;

  always_ff @(posedge clk) begin
    if (!n_rst) begin
      busy_o <= 1'b0;
    end else if (start_i) begin
      busy_o <= 1'b1;
    end else if (done_o) begin
      busy_o <= 1'b0;
    end
  end

  // Corners arrive in any order
  always_ff @(posedge clk) begin
    if (start_i) begin
      x_min <= (x1_i < x2_i) ? x1_i : x2_i;
      x_max <= (x1_i < x2_i) ? x2_i : x1_i;
      y_max <= (y1_i < y2_i) ? y2_i : y1_i;
      addr_x_o <= (x1_i < x2_i) ? x1_i : x2_i;
      addr_y_o <= (y1_i < y2_i) ? y1_i : y2_i;
      pixel_o <= pixel_i;
    end else if (busy_o && gnt_i && !last_pixel) begin
      // Row-major scan
      if (last_x) begin
        addr_x_o <= x_min;
        addr_y_o <= addr_y_o + 1'b1;
      end else begin
        addr_x_o <= addr_x_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gpu_rect_outline.sv ====
`default_nettype none

module gpu_rect_outline (
  input  logic clk,
  input  logic n_rst,
  input  logic start_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x1_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y1_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x2_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y2_i,
  input  logic [gpu_mem_pkg::PIXEL_BITS-1:0] pixel_i,
  input  logic gnt_i,
  output logic req_o,
  output logic [gpu_geom_pkg::WIDTH_BITS-1:0] addr_x_o,
  output logic [gpu_geom_pkg::HEIGHT_BITS-1:0] addr_y_o,
  output logic [gpu_mem_pkg::PIXEL_BITS-1:0] pixel_o,
  output logic busy_o,
  output logic done_o
);

  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x_min;
  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x_max;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y_min;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y_max;
  logic edge_row;
  logic last_x;
  logic last_pixel;

  assign edge_row = (addr_y_o == y_min) || (addr_y_o == y_max);
  assign last_x = (addr_x_o == x_max);
  assign last_pixel = last_x && (addr_y_o == y_max);
  assign req_o = busy_o;
  assign done_o = busy_o && gnt_i && last_pixel;

  always_ff @(posedge clk) begin
    if (!n_rst) begin
      busy_o <= 1'b0;
    end else if (start_i) begin
      busy_o <= 1'b1;
    end else if (done_o) begin
      busy_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      x_min <= (x1_i < x2_i) ? x1_i : x2_i;
      x_max <= (x1_i < x2_i) ? x2_i : x1_i;
      y_min <= (y1_i < y2_i) ? y1_i : y2_i;
      y_max <= (y1_i < y2_i) ? y2_i : y1_i;
      addr_x_o <= (x1_i < x2_i) ? x1_i : x2_i;
      addr_y_o <= (y1_i < y2_i) ? y1_i : y2_i;
      pixel_o <= pixel_i;
    end else if (busy_o && gnt_i && !last_pixel) begin
      if (last_x) begin
        // A one-column box lands here at once, so no pixel repeats
        addr_x_o <= x_min;
        addr_y_o <= addr_y_o + 1'b1;
      end else if (!edge_row && addr_x_o == x_min) begin
        // Interior row, jump straight to the right edge
        addr_x_o <= x_max;
      end else begin
        addr_x_o <= addr_x_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gpu_fb_arbiter.sv ====
`default_nettype none

module gpu_fb_arbiter (
  input  logic [gpu_mem_pkg::NUM_REQ-1:0] req_i,
  input  logic [gpu_mem_pkg::NUM_REQ-1:0][gpu_geom_pkg::WIDTH_BITS-1:0] x_i,
  input  logic [gpu_mem_pkg::NUM_REQ-1:0][gpu_geom_pkg::HEIGHT_BITS-1:0] y_i,
  input  logic [gpu_mem_pkg::REQ_HOST-1:0][gpu_mem_pkg::PIXEL_BITS-1:0] wr_pixel_i,
  output logic [gpu_mem_pkg::NUM_REQ-1:0] gnt_o,
  output logic mem_we_o,
  output logic mem_re_o,
  output logic [gpu_geom_pkg::WIDTH_BITS-1:0] mem_x_o,
  output logic [gpu_geom_pkg::HEIGHT_BITS-1:0] mem_y_o,
  output logic [gpu_mem_pkg::PIXEL_BITS-1:0] mem_pixel_o
);

  // Walk from the top index down so the lowest requester is kept
  always_comb begin
    gnt_o = '0;
    mem_x_o = '0;
    mem_y_o = '0;
    for (int i = gpu_mem_pkg::NUM_REQ - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        gnt_o = '0;
        gnt_o[i] = 1'b1;
        mem_x_o = x_i[i];
        mem_y_o = y_i[i];
      end
    end
  end

  // Engines below the host index write, the host reads
  assign mem_we_o = |gnt_o[gpu_mem_pkg::REQ_HOST-1:0];
  assign mem_re_o = gnt_o[gpu_mem_pkg::REQ_HOST];
  assign mem_pixel_o = gnt_o[gpu_mem_pkg::REQ_FILL] ? wr_pixel_i[gpu_mem_pkg::REQ_FILL]
                                                     : wr_pixel_i[gpu_mem_pkg::REQ_OUTLINE];

  always_comb begin
    a_gnt_onehot: assert ($onehot0(gnt_o));
  end

endmodule

`default_nettype wire

// ==== hdl/gpu_frame_buffer.sv ====
`default_nettype none

module gpu_frame_buffer #(
  parameter int FB_W = 32,
  parameter int FB_H = 16
) (
  input  logic clk,
  input  logic n_rst,
  input  logic we_i,
  input  logic re_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y_i,
  input  logic [gpu_mem_pkg::PIXEL_BITS-1:0] pixel_i,
  output logic [gpu_mem_pkg::PIXEL_BITS-1:0] rd_pixel_o,
  output logic rd_valid_o
);

  localparam int XW = $clog2(FB_W);
  localparam int YW = $clog2(FB_H);

  logic [gpu_mem_pkg::PIXEL_BITS-1:0] mem [FB_H][FB_W];
  logic on_screen;

  // Clipping
  assign on_screen = (x_i < FB_W) && (y_i < FB_H);

  always_ff @(posedge clk) begin
    if (!n_rst) begin
      for (int row = 0; row < FB_H; row++) begin
        for (int col = 0; col < FB_W; col++) begin
          mem[row][col] <= '0;
        end
      end
    end else if (we_i && on_screen) begin
      mem[y_i[YW-1:0]][x_i[XW-1:0]] <= pixel_i;
    end
  end

  // A request held through its valid cycle is not served twice
  always_ff @(posedge clk) begin
    if (!n_rst) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= re_i && !rd_valid_o;
    end
  end

  always_ff @(posedge clk) begin
    if (re_i) begin
      rd_pixel_o <= on_screen ? mem[y_i[YW-1:0]][x_i[XW-1:0]] : '0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gpu_top.sv ====
`default_nettype none

module gpu_top #(
  parameter int FB_W = 32,
  parameter int FB_H = 16,
  parameter int FIFO_DEPTH = 8
) (
  input  logic clk,
  input  logic n_rst,
  input  logic push_instruction_i,
  input  logic [gpu_geom_pkg::OPCODE_BITS-1:0] opcode_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x1_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y1_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x2_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y2_i,
  input  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] r_i,
  input  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] g_i,
  input  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] b_i,
  output logic fifo_full_o,
  output logic busy_o,
  input  logic rd_req_i,
  input  logic [gpu_geom_pkg::WIDTH_BITS-1:0] rd_x_i,
  input  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] rd_y_i,
  output logic [gpu_mem_pkg::PIXEL_BITS-1:0] rd_pixel_o,
  output logic rd_valid_o
);

  // FIFO head
  logic [gpu_geom_pkg::OPCODE_BITS-1:0] head_opcode;
  logic [gpu_geom_pkg::WIDTH_BITS-1:0] head_x1, head_x2;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] head_y1, head_y2;
  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] head_r, head_g, head_b;
  logic fifo_empty;
  logic pop;

  // Latched command for the engines
  logic [gpu_geom_pkg::WIDTH_BITS-1:0] cmd_x1, cmd_x2;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] cmd_y1, cmd_y2;
  logic [gpu_mem_pkg::PIXEL_BITS-1:0] cmd_pixel;
  logic fill_start, outline_start;

  logic fill_req, fill_busy;
  logic outline_req, outline_busy;
  logic [gpu_geom_pkg::WIDTH_BITS-1:0] fill_x, outline_x, mem_x;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] fill_y, outline_y, mem_y;
  logic [gpu_mem_pkg::PIXEL_BITS-1:0] fill_pixel, outline_pixel, mem_pixel;
  logic [gpu_mem_pkg::NUM_REQ-1:0] gnt;
  logic mem_we, mem_re;

  gpu_instruction_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .n_rst(n_rst), .push_i(push_instruction_i), .pop_i(pop),
    .opcode_i(opcode_i), .x1_i(x1_i), .y1_i(y1_i), .x2_i(x2_i), .y2_i(y2_i),
    .r_i(r_i), .g_i(g_i), .b_i(b_i),
    .opcode_o(head_opcode), .x1_o(head_x1), .y1_o(head_y1), .x2_o(head_x2),
    .y2_o(head_y2), .r_o(head_r), .g_o(head_g), .b_o(head_b),
    .empty_o(fifo_empty), .full_o(fifo_full_o)
  );

  gpu_command_dispatch u_dispatch (
    .clk(clk), .n_rst(n_rst), .empty_i(fifo_empty), .opcode_i(head_opcode),
    .x1_i(head_x1), .y1_i(head_y1), .x2_i(head_x2), .y2_i(head_y2),
    .pixel_i({head_r, head_g, head_b}),
    .fill_busy_i(fill_busy), .outline_busy_i(outline_busy), .pop_o(pop),
    .fill_start_o(fill_start), .outline_start_o(outline_start),
    .x1_o(cmd_x1), .y1_o(cmd_y1), .x2_o(cmd_x2), .y2_o(cmd_y2),
    .pixel_o(cmd_pixel), .busy_o(busy_o)
  );

  gpu_rect_fill u_fill (
    .clk(clk), .n_rst(n_rst), .start_i(fill_start),
    .x1_i(cmd_x1), .y1_i(cmd_y1), .x2_i(cmd_x2), .y2_i(cmd_y2), .pixel_i(cmd_pixel),
    .gnt_i(gnt[gpu_mem_pkg::REQ_FILL]), .req_o(fill_req),
    .addr_x_o(fill_x), .addr_y_o(fill_y), .pixel_o(fill_pixel),
    .busy_o(fill_busy), .done_o()
  );

  gpu_rect_outline u_outline (
    .clk(clk), .n_rst(n_rst), .start_i(outline_start),
    .x1_i(cmd_x1), .y1_i(cmd_y1), .x2_i(cmd_x2), .y2_i(cmd_y2), .pixel_i(cmd_pixel),
    .gnt_i(gnt[gpu_mem_pkg::REQ_OUTLINE]), .req_o(outline_req),
    .addr_x_o(outline_x), .addr_y_o(outline_y), .pixel_o(outline_pixel),
    .busy_o(outline_busy), .done_o()
  );

  // Concatenation order is host, outline, fill to match the requester indices
  gpu_fb_arbiter u_arbiter (
    .req_i({rd_req_i, outline_req, fill_req}),
    .x_i({rd_x_i, outline_x, fill_x}),
    .y_i({rd_y_i, outline_y, fill_y}),
    .wr_pixel_i({outline_pixel, fill_pixel}),
    .gnt_o(gnt), .mem_we_o(mem_we), .mem_re_o(mem_re),
    .mem_x_o(mem_x), .mem_y_o(mem_y), .mem_pixel_o(mem_pixel)
  );

  gpu_frame_buffer #(.FB_W(FB_W), .FB_H(FB_H)) u_frame_buffer (
    .clk(clk), .n_rst(n_rst), .we_i(mem_we), .re_i(mem_re),
    .x_i(mem_x), .y_i(mem_y), .pixel_i(mem_pixel),
    .rd_pixel_o(rd_pixel_o), .rd_valid_o(rd_valid_o)
  );

endmodule

`default_nettype wire

// ==== tests/gpu_tb.sv ====
`default_nettype none

module gpu_tb;

  localparam int FB_W = 32;
  localparam int FB_H = 16;
  localparam int FIFO_DEPTH = 8;
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DELAY = 10;

  // Run length sets the watchdog budget
  localparam int NUM_FILL = 12;
  localparam int NUM_MIXED = 12;
  localparam int NUM_ORDER = 9;
  localparam int NUM_DISCARD = 6;
  localparam int NUM_INSTR = NUM_FILL + NUM_MIXED + NUM_ORDER + NUM_DISCARD;
  localparam int NUM_OFFSCREEN = 4;
  localparam int NUM_READS = 5 * FB_W * FB_H + NUM_OFFSCREEN;
  localparam int TIMEOUT_CYCLES = 200 * NUM_INSTR + 20 * NUM_READS + 10;

  logic clk;
  logic n_rst;
  logic push_instruction;
  logic [gpu_geom_pkg::OPCODE_BITS-1:0] opcode;
  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x1;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y1;
  logic [gpu_geom_pkg::WIDTH_BITS-1:0] x2;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] y2;
  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] r;
  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] g;
  logic [gpu_geom_pkg::CHANNEL_BITS-1:0] b;
  logic fifo_full;
  logic busy;
  logic rd_req;
  logic [gpu_geom_pkg::WIDTH_BITS-1:0] rd_x;
  logic [gpu_geom_pkg::HEIGHT_BITS-1:0] rd_y;
  logic [gpu_mem_pkg::PIXEL_BITS-1:0] rd_pixel;
  logic rd_valid;

  // Expected screen contents
  logic [gpu_mem_pkg::PIXEL_BITS-1:0] model [FB_H][FB_W];
  logic [31:0] seed;
  int error_count;

  gpu_top #(.FB_W(FB_W), .FB_H(FB_H), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk(clk), .n_rst(n_rst), .push_instruction_i(push_instruction),
    .opcode_i(opcode), .x1_i(x1), .y1_i(y1), .x2_i(x2), .y2_i(y2),
    .r_i(r), .g_i(g), .b_i(b),
    .fifo_full_o(fifo_full), .busy_o(busy),
    .rd_req_i(rd_req), .rd_x_i(rd_x), .rd_y_i(rd_y),
    .rd_pixel_o(rd_pixel), .rd_valid_o(rd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the DUT did not go idle or answer a read within %0d cycles",
             TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Upper bits of the LCG are the better ones
  function automatic int rand_below(input int limit);
    logic [31:0] value;
    value = next_rand();
    return int'(value[31:8]) % limit;
  endfunction

  function automatic logic [gpu_mem_pkg::PIXEL_BITS-1:0] random_pixel();
    logic [31:0] value;
    value = next_rand();
    return value[gpu_mem_pkg::PIXEL_BITS-1:0];
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_pixel(input string name,
                             input logic [gpu_mem_pkg::PIXEL_BITS-1:0] expected,
                             input logic [gpu_mem_pkg::PIXEL_BITS-1:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s expected %b actual %b", name, expected, actual);
    end
  endtask

  // Fill paints the whole box and outline only its min and max rows and columns
  task automatic draw_model(input logic [gpu_geom_pkg::OPCODE_BITS-1:0] op,
                            input int xa, input int ya, input int xb, input int yb,
                            input logic [gpu_mem_pkg::PIXEL_BITS-1:0] color);
    int x_lo;
    int x_hi;
    int y_lo;
    int y_hi;
    logic on_border;
    x_lo = (xa < xb) ? xa : xb;
    x_hi = (xa < xb) ? xb : xa;
    y_lo = (ya < yb) ? ya : yb;
    y_hi = (ya < yb) ? yb : ya;
    for (int y = y_lo; y <= y_hi; y++) begin
      for (int x = x_lo; x <= x_hi; x++) begin
        on_border = (x == x_lo) || (x == x_hi) || (y == y_lo) || (y == y_hi);
        if (x < FB_W && y < FB_H) begin
          if (op == gpu_geom_pkg::OP_FILL_RECT) begin
            model[y][x] = color;
          end else if (op == gpu_geom_pkg::OP_OUTLINE_RECT && on_border) begin
            model[y][x] = color;
          end
        end
      end
    end
  endtask

  task automatic push_instr(input logic [gpu_geom_pkg::OPCODE_BITS-1:0] op,
                            input int xa, input int ya, input int xb, input int yb,
                            input logic [gpu_mem_pkg::PIXEL_BITS-1:0] color);
    push_instruction = 1'b1;
    opcode = op;
    x1 = xa[gpu_geom_pkg::WIDTH_BITS-1:0];
    y1 = ya[gpu_geom_pkg::HEIGHT_BITS-1:0];
    x2 = xb[gpu_geom_pkg::WIDTH_BITS-1:0];
    y2 = yb[gpu_geom_pkg::HEIGHT_BITS-1:0];
    {r, g, b} = color;
    next_cycle();
    push_instruction = 1'b0;
    draw_model(op, xa, ya, xb, yb, color);
  endtask

  task automatic wait_room();
    while (fifo_full) begin
      next_cycle();
    end
  endtask

  task automatic wait_idle();
    while (busy) begin
      next_cycle();
    end
  endtask

  // Shape 1 gives a single row and shape 2 a single column
  task automatic random_box(input int shape, output int xa, output int ya,
                            output int xb, output int yb);
    int lo_x;
    int hi_x;
    int lo_y;
    int hi_y;
    lo_x = rand_below(40);
    hi_x = lo_x + rand_below(12);
    lo_y = rand_below(20);
    hi_y = lo_y + rand_below(8);
    if (shape == 1) begin
      hi_y = lo_y;
    end
    if (shape == 2) begin
      hi_x = lo_x;
    end
    xa = lo_x;
    xb = hi_x;
    if (rand_below(2) == 1) begin
      xa = hi_x;
      xb = lo_x;
    end
    ya = lo_y;
    yb = hi_y;
    if (rand_below(2) == 1) begin
      ya = hi_y;
      yb = lo_y;
    end
  endtask

  task automatic read_pixel(input int x, input int y,
                            output logic [gpu_mem_pkg::PIXEL_BITS-1:0] data);
    rd_req = 1'b1;
    rd_x = x[gpu_geom_pkg::WIDTH_BITS-1:0];
    rd_y = y[gpu_geom_pkg::HEIGHT_BITS-1:0];
    next_cycle();
    while (!rd_valid) begin
      next_cycle();
    end
    data = rd_pixel;
    rd_req = 1'b0;
  endtask

  task automatic read_back(input string name);
    logic [gpu_mem_pkg::PIXEL_BITS-1:0] data;
    for (int y = 0; y < FB_H; y++) begin
      for (int x = 0; x < FB_W; x++) begin
        read_pixel(x, y, data);
        check_pixel($sformatf("%s at (%0d,%0d)", name, x, y), model[y][x], data);
      end
    end
  endtask

  initial begin
    int xa;
    int ya;
    int xb;
    int yb;
    int code;
    logic [gpu_geom_pkg::OPCODE_BITS-1:0] op;
    logic [gpu_mem_pkg::PIXEL_BITS-1:0] data;
    seed = 32'h1f15_d6dc;
    error_count = 0;
    n_rst = 1'b0;
    push_instruction = 1'b0;
    opcode = '0;
    x1 = '0;
    y1 = '0;
    x2 = '0;
    y2 = '0;
    r = '0;
    g = '0;
    b = '0;
    rd_req = 1'b0;
    rd_x = '0;
    rd_y = '0;
    for (int y = 0; y < FB_H; y++) begin
      for (int x = 0; x < FB_W; x++) begin
        model[y][x] = '0;
      end
    end
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    n_rst = 1'b1;

    check_flag("reset fifo_full", 1'b0, fifo_full);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset rd_valid", 1'b0, rd_valid);
    read_back("reset");

    // Fills partly off screen with corners in either order
    for (int i = 0; i < NUM_FILL; i++) begin
      random_box(0, xa, ya, xb, yb);
      wait_room();
      push_instr(gpu_geom_pkg::OP_FILL_RECT, xa, ya, xb, yb, random_pixel());
    end
    wait_idle();
    read_back("fill");

    // Outlines drawn over the fills with a few fills mixed in
    for (int i = 0; i < NUM_MIXED; i++) begin
      random_box(i % 3, xa, ya, xb, yb);
      op = (i % 4 == 3) ? gpu_geom_pkg::OP_FILL_RECT : gpu_geom_pkg::OP_OUTLINE_RECT;
      wait_room();
      push_instr(op, xa, ya, xb, yb, random_pixel());
    end
    wait_idle();
    read_back("outline");

    // Full-screen fill keeps the engines busy while the queue fills up
    push_instr(gpu_geom_pkg::OP_FILL_RECT, FB_W - 1, 0, 0, FB_H - 1, random_pixel());
    for (int i = 0; i < NUM_ORDER - 1; i++) begin
      random_box(i % 3, xa, ya, xb, yb);
      op = (i % 2 == 1) ? gpu_geom_pkg::OP_OUTLINE_RECT : gpu_geom_pkg::OP_FILL_RECT;
      check_flag("order room before push", 1'b0, fifo_full);
      push_instr(op, xa, ya, xb, yb, random_pixel());
    end
    check_flag("order fifo_full after eight pushes", 1'b1, fifo_full);
    check_flag("order busy while drawing", 1'b1, busy);
    wait_idle();
    read_back("order");

    // NOP and unknown opcodes leave the screen alone
    for (int i = 0; i < NUM_DISCARD; i++) begin
      random_box(0, xa, ya, xb, yb);
      code = 3 + rand_below(13);
      op = (i == 0) ? gpu_geom_pkg::OP_NOP : code[gpu_geom_pkg::OPCODE_BITS-1:0];
      wait_room();
      push_instr(op, xa, ya, xb, yb, random_pixel());
    end
    wait_idle();
    read_back("discard");

    // Off-screen reads alternate between x and y out of range
    for (int i = 0; i < NUM_OFFSCREEN; i++) begin
      if (i % 2 == 0) begin
        read_pixel(FB_W + rand_below(64), rand_below(FB_H), data);
      end else begin
        read_pixel(rand_below(FB_W), FB_H + rand_below(32), data);
      end
      check_pixel($sformatf("offscreen read %0d", i), '0, data);
    end

    $display("Test finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/gpu_geom_pkg.sv
hdl/gpu_mem_pkg.sv
hdl/gpu_instruction_fifo.sv
hdl/gpu_command_dispatch.sv
hdl/gpu_rect_fill.sv
hdl/gpu_rect_outline.sv
hdl/gpu_fb_arbiter.sv
hdl/gpu_frame_buffer.sv
hdl/gpu_top.sv
tests/gpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
TOP = gpu_tb
FLIST = flist.f
BUILD_DIR = obj_dir
LOG = sim.log
VFLAGS = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
